/* dv/rms_front_ref.svh */
`ifndef RMS_FRONT_REF_SVH
`define RMS_FRONT_REF_SVH

// ---------------------------------------------------------------------------
// Reference model of the conversion and the sum of squares
// ---------------------------------------------------------------------------

// Truncating bfloat16 of a signed integer, zero maps to zero
function automatic logic [15:0] bf16_of_int(input longint value);
  longint      mag;
  int          top;
  logic [6:0]  man;
  logic [15:0] result;
  mag    = (value < 0) ? -value : value;
  result = 16'h0000;
  if (mag != 0) begin
    top = 0;
    while ((mag >> (top + 1)) != 0) begin
      top++;
    end
    // Seven bits right below the leading one
    if (top >= 7) begin
      man = 7'(mag >> (top - 7));
    end else begin
      man = 7'(mag << (7 - top));
    end
    result = {value < 0, 8'(top + 127), man};
  end
  return result;
endfunction

// Exponent lowered by the scale position, zero stays zero
function automatic logic [15:0] scale_exponent_ref(input logic [15:0] value, input int scale);
  int field;
  if (value == 16'h0000) begin
    return 16'h0000;
  end
  field = int'(value[14:0]) - scale * 128;
  return {value[15], 15'(field)};
endfunction

// Squares of the first k valid elements in lane order
function automatic longint sum_of_squares(input int elems[$], input int k);
  longint acc;
  acc = 0;
  for (int n = 0; n < k && n < elems.size(); n++) begin
    acc += longint'(elems[n]) * longint'(elems[n]);
  end
  return acc;
endfunction

`endif

/* dv/rms_front_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rms_front_tb;

  import rms_front_pkg::*;

  logic                          clk;
  logic                          rst_n;
  logic [num_width-1:0]          in_data_num;
  logic                          in_data_num_vld;
  logic [num_width-1:0]          in_k;
  logic                          in_k_vld;
  logic signed [scale_width-1:0] in_scale_pos;
  logic                          in_scale_pos_vld;
  fixed_lanes_t                  in_fixed_data;
  lane_mask_t                    in_fixed_data_vld;
  lane_bf16_t                    in_gamma;
  lane_mask_t                    in_gamma_vld;
  bf16_t                         sum_sq;
  logic                          sum_sq_vld;
  lane_bf16_t                    out_x;
  lane_bf16_t                    out_gamma;
  lane_mask_t                    out_vld;
  logic                          out_last;

  // One vector per entry
  string test_names [5] = '{"conversion", "scaling", "k_limit", "partial_masks", "back_to_back"};
  int    test_num   [5] = '{32, 32, 40, 45, 24};
  int    test_k     [5] = '{32, 32, 21, 13, 17};
  int    test_scale [5] = '{0, 3, -2, 1, -1};
  bit    test_sparse[5] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  int seed;
  int cycle_cnt = 0;
  int cycle_limit;

  // Filled by the stimulus and drained by the compare process
  logic [15:0] exp_sum_q   [$];
  int          sum_tid_q   [$];
  lane_bf16_t  exp_x_q     [$];
  lane_bf16_t  exp_gamma_q [$];
  lane_mask_t  exp_mask_q  [$];
  bit          exp_last_q  [$];
  int          beat_tid_q  [$];

  `include "rms_front_ref.svh"

  rms_front_top u_rms_front_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_data_num      (in_data_num),
    .in_data_num_vld  (in_data_num_vld),
    .in_k             (in_k),
    .in_k_vld         (in_k_vld),
    .in_scale_pos     (in_scale_pos),
    .in_scale_pos_vld (in_scale_pos_vld),
    .in_fixed_data    (in_fixed_data),
    .in_fixed_data_vld(in_fixed_data_vld),
    .in_gamma         (in_gamma),
    .in_gamma_vld     (in_gamma_vld),
    .sum_sq           (sum_sq),
    .sum_sq_vld       (sum_sq_vld),
    .out_x            (out_x),
    .out_gamma        (out_gamma),
    .out_vld          (out_vld),
    .out_last         (out_last)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("Verification failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input string name, input logic [127:0] expected,
                       input logic [127:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      abort_run("A DUT output did not match the expected value");
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      abort_run("Timeout, the DUT stopped producing results");
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus for one vector and its expected results
  // ---------------------------------------------------------------------------
  task automatic run_vector(input int tid);
    logic signed [fixed_width-1:0] data [buffer_depth][lane_count];
    lane_mask_t                    mask [buffer_depth];
    lane_bf16_t                    gamma [buffer_depth];
    lane_bf16_t                    exp_x;
    int                            elems [$];
    int                            nbeats;
    int                            k;
    nbeats = (test_num[tid] + lane_count - 1) / lane_count;
    for (int b = 0; b < nbeats; b++) begin
      mask[b] = test_sparse[tid] ? lane_mask_t'($random(seed) & $random(seed)) : '1;
      // Every slot needs at least one valid lane
      if (mask[b] == '0) begin
        mask[b][b % lane_count] = 1'b1;
      end
      for (int i = 0; i < lane_count; i++) begin
        data[b][i] = fixed_width'($random(seed));
        if (($random(seed) & 7) == 0) begin
          data[b][i] = '0;
        end
        gamma[b][i] = 16'($random(seed));
        if (mask[b][i]) begin
          elems.push_back(int'(data[b][i]));
        end
      end
    end
    k = (test_k[tid] < elems.size()) ? test_k[tid] : elems.size();
    exp_sum_q.push_back(scale_exponent_ref(bf16_of_int(sum_of_squares(elems, k)),
                                           test_scale[tid]));
    sum_tid_q.push_back(tid);
    for (int b = 0; b < nbeats; b++) begin
      for (int i = 0; i < lane_count; i++) begin
        exp_x[i] = scale_exponent_ref(bf16_of_int(longint'(data[b][i])), test_scale[tid]);
      end
      exp_x_q.push_back(exp_x);
      exp_gamma_q.push_back(gamma[b]);
      exp_mask_q.push_back(mask[b]);
      exp_last_q.push_back(b == nbeats - 1);
      beat_tid_q.push_back(tid);
    end

    // Configuration one cycle ahead of the data
    @(posedge clk);
    #1;
    in_data_num      = num_width'(test_num[tid]);
    in_data_num_vld  = 1'b1;
    in_k             = num_width'(k);
    in_k_vld         = 1'b1;
    in_scale_pos     = scale_width'(test_scale[tid]);
    in_scale_pos_vld = 1'b1;
    for (int b = 0; b < nbeats; b++) begin
      @(posedge clk);
      #1;
      in_data_num_vld  = 1'b0;
      in_k_vld         = 1'b0;
      in_scale_pos_vld = 1'b0;
      for (int i = 0; i < lane_count; i++) begin
        in_fixed_data[i] = data[b][i];
      end
      in_fixed_data_vld = mask[b];
      in_gamma          = gamma[b];
      in_gamma_vld      = mask[b];
    end
    @(posedge clk);
    #1;
    in_fixed_data_vld = '0;
    in_gamma_vld      = '0;
    // Next vector only after the final replay beat
    while (!out_last) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : stimulus
    seed        = 3208;
    cycle_limit = 200;
    for (int t = 0; t < 5; t++) begin
      cycle_limit += 40 * ((test_num[t] + lane_count - 1) / lane_count);
    end
    rst_n             = 1'b0;
    in_data_num       = '0;
    in_data_num_vld   = 1'b0;
    in_k              = '0;
    in_k_vld          = 1'b0;
    in_scale_pos      = '0;
    in_scale_pos_vld  = 1'b0;
    in_fixed_data     = '0;
    in_fixed_data_vld = '0;
    in_gamma          = '0;
    in_gamma_vld      = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int t = 0; t < 5; t++) begin
      run_vector(t);
    end
    repeat (10) @(posedge clk);
    if (exp_sum_q.size() != 0 || exp_mask_q.size() != 0) begin
      abort_run("Some expected results never appeared at the DUT outputs");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Compare process that samples the outputs mid-cycle
  // ---------------------------------------------------------------------------
  initial begin : compare
    lane_bf16_t exp_x;
    lane_mask_t exp_mask;
    string      name;
    forever begin
      @(negedge clk);
      if (sum_sq_vld) begin
        if (exp_sum_q.size() == 0) begin
          abort_run("sum_sq_vld pulsed while no vector was waiting for its sum");
        end else begin
          name = test_names[sum_tid_q.pop_front()];
          check({name, " sum_sq"}, exp_sum_q.pop_front(), sum_sq);
        end
      end
      if (out_vld != '0 || out_last) begin
        if (exp_mask_q.size() == 0) begin
          abort_run("A replay beat appeared with no beat expected");
        end else begin
          name     = test_names[beat_tid_q.pop_front()];
          exp_x    = exp_x_q.pop_front();
          exp_mask = exp_mask_q.pop_front();
          check({name, " out_vld"}, exp_mask, out_vld);
          check({name, " out_last"}, exp_last_q.pop_front(), out_last);
          check({name, " out_gamma"}, exp_gamma_q.pop_front(), out_gamma);
          for (int i = 0; i < lane_count; i++) begin
            if (exp_mask[i]) begin
              check($sformatf("%s out_x lane %0d", name, i), exp_x[i], out_x[i]);
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, exit status follows the run

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module rms_front_tb -Mdir obj_dir &&
./obj_dir/Vrms_front_tb ||
{
  echo "Simulation run did not complete successfully"
  exit 1
}

/* src/i2flt_bf16.sv */
`timescale 1ns/10ps
`default_nettype none

module i2flt_bf16 #(
  parameter int in_width = 8
) (
  input  logic signed [in_width-1:0] a,
  output rms_front_pkg::bf16_t       z
);

  import rms_front_pkg::*;

  logic                sign;
  logic [in_width-1:0] abs_val;
  logic [in_width-1:0] norm;
  int                  msb;

  always_comb begin
    sign    = a[in_width-1];
    abs_val = sign ? in_width'(-a) : in_width'(a);

    // Position of the leading one
    msb = 0;
    for (int i = 0; i < in_width; i++) begin
      if (abs_val[i]) begin
        msb = i;
      end
    end

    // Leading one moves to the top bit, the bits below it become the mantissa
    norm = abs_val << (in_width - 1 - msb);

    if (abs_val == '0) begin
      z = '0;
    end else begin
      z.sign     = sign;
      z.exponent = exp_width'(msb + exp_bias);
      z.mantissa = norm[in_width-2 -: man_width];
    end
  end

endmodule

`default_nettype wire

/* src/in_data_convert.sv */
`timescale 1ns/10ps
`default_nettype none

module in_data_convert (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic signed [rms_front_pkg::scale_width-1:0] in_scale_pos,
  input  logic                                      in_scale_pos_vld,
  input  rms_front_pkg::fixed_lanes_t               in_fixed_data,
  input  rms_front_pkg::lane_mask_t                 in_fixed_data_vld,
  output rms_front_pkg::lane_bf16_t                 x_float,
  output rms_front_pkg::lane_mask_t                 x_vld,
  output logic signed [rms_front_pkg::scale_width-1:0] scale_pos
);

  import rms_front_pkg::*;

  lane_bf16_t lane_flt;

  // Input scale position, held until reconfigured
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scale_pos <= '0;
    end else if (in_scale_pos_vld) begin
      scale_pos <= in_scale_pos;
    end
  end

  // --------------------------------------------------------------------------
  // Per-lane conversion
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < lane_count; i++) begin : g_lane
    i2flt_bf16 #(
      .in_width(fixed_width)
    ) u_i2flt (
      .a(signed'(in_fixed_data[i])),
      .z(lane_flt[i])
    );
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < lane_count; i++) begin
      x_float[i] <= scale_exponent(lane_flt[i], scale_pos);
    end
  end

  // Lane valids follow the data by one register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_vld <= '0;
    end else begin
      x_vld <= in_fixed_data_vld;
    end
  end

endmodule

`default_nettype wire

/* src/replay_control.sv */
`timescale 1ns/10ps
`default_nettype none

module replay_control (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [rms_front_pkg::num_width-1:0] in_data_num,
  input  logic                                in_data_num_vld,
  input  logic                                sum_sq_vld,
  output logic                                rd_en,
  output logic                                out_last
);

  import rms_front_pkg::*;

  logic [num_width-1:0] data_num;
  logic [num_width:0]   rd_cnt;
  logic                 last_slot;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_num <= '0;
    end else if (in_data_num_vld) begin
      data_num <= in_data_num;
    end
  end

  // Slot being issued now covers the tail of the vector
  assign last_slot = (rd_cnt + (num_width + 1)'(lane_count)) >= {1'b0, data_num};

  // --------------------------------------------------------------------------
  // Read enable and element count
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en <= 1'b0;
    end else if (sum_sq_vld) begin
      rd_en <= 1'b1;
    end else if (rd_en && last_slot) begin
      rd_en <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_cnt <= '0;
    end else if (out_last) begin
      rd_cnt <= '0;
    end else if (rd_en) begin
      rd_cnt <= rd_cnt + (num_width + 1)'(lane_count);
    end
  end

  // Registered like the buffer read, so it lines up with the final beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_last <= 1'b0;
    end else begin
      out_last <= rd_en && last_slot;
    end
  end

  a_no_restart: assert property (
    @(posedge clk) disable iff (!rst_n) sum_sq_vld |-> !rd_en
  );

endmodule

`default_nettype wire

/* src/rms_front_pkg.sv */
`default_nettype none

package rms_front_pkg;

  // --------------------------------------------------------------------------
  // Bus geometry and number formats
  // --------------------------------------------------------------------------
  localparam int lane_count   = 8;
  localparam int fixed_width  = 8;
  localparam int exp_width    = 8;
  localparam int man_width    = 7;
  localparam int exp_bias     = 2 ** (exp_width - 1) - 1;
  localparam int num_width    = 10;
  localparam int sum_width    = 24;
  localparam int scale_width  = 5;

  // One spare slot beyond a 256 element vector
  localparam int buffer_depth = 256 / lane_count + 1;

  typedef logic [$clog2(buffer_depth + 1)-1:0] slot_ptr_t;

  typedef struct packed {
    logic                 sign;
    logic [exp_width-1:0] exponent;
    logic [man_width-1:0] mantissa;
  } bf16_t;

  typedef bf16_t [lane_count-1:0] lane_bf16_t;
  typedef logic [lane_count-1:0] lane_mask_t;
  typedef logic signed [lane_count-1:0][fixed_width-1:0] fixed_lanes_t;

  // Removes a binary point position from a bfloat16 value.
  // The offset is subtracted from exponent and mantissa together, zero is kept
  function automatic bf16_t scale_exponent(
    input bf16_t                         value,
    input logic signed [scale_width-1:0] scale
  );
    logic [exp_width+man_width-1:0] offset;
    logic [exp_width+man_width-1:0] field;
    bf16_t                          result;
    offset = (exp_width + man_width)'(scale) << man_width;
    field  = {value.exponent, value.mantissa} - offset;
    result = '0;
    if (value != '0) begin
      result.sign                      = value.sign;
      {result.exponent, result.mantissa} = field;
    end
    return result;
  endfunction

endpackage

`default_nettype wire

/* src/rms_front_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rms_front_top (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [rms_front_pkg::num_width-1:0]       in_data_num,
  input  logic                                      in_data_num_vld,
  input  logic [rms_front_pkg::num_width-1:0]       in_k,
  input  logic                                      in_k_vld,
  input  logic signed [rms_front_pkg::scale_width-1:0] in_scale_pos,
  input  logic                                      in_scale_pos_vld,
  input  rms_front_pkg::fixed_lanes_t               in_fixed_data,
  input  rms_front_pkg::lane_mask_t                 in_fixed_data_vld,
  input  rms_front_pkg::lane_bf16_t                 in_gamma,
  input  rms_front_pkg::lane_mask_t                 in_gamma_vld,
  output rms_front_pkg::bf16_t                      sum_sq,
  output logic                                      sum_sq_vld,
  output rms_front_pkg::lane_bf16_t                 out_x,
  output rms_front_pkg::lane_bf16_t                 out_gamma,
  output rms_front_pkg::lane_mask_t                 out_vld,
  output logic                                      out_last
);

  import rms_front_pkg::*;

  lane_bf16_t                    x_float;
  lane_mask_t                    x_vld;
  logic signed [scale_width-1:0] scale_pos;
  logic                          rd_en;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  in_data_convert u_in_data_convert (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_scale_pos     (in_scale_pos),
    .in_scale_pos_vld (in_scale_pos_vld),
    .in_fixed_data    (in_fixed_data),
    .in_fixed_data_vld(in_fixed_data_vld),
    .x_float          (x_float),
    .x_vld            (x_vld),
    .scale_pos        (scale_pos)
  );

  // Squares the raw lanes, not the converted ones
  square_accumulator u_square_accumulator (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_k             (in_k),
    .in_k_vld         (in_k_vld),
    .in_fixed_data    (in_fixed_data),
    .in_fixed_data_vld(in_fixed_data_vld),
    .scale_pos        (scale_pos),
    .clear            (out_last),
    .sum_sq           (sum_sq),
    .sum_sq_vld       (sum_sq_vld)
  );

  // --------------------------------------------------------------------------
  // Slot buffers and replay
  // --------------------------------------------------------------------------
  vector_buffer #(
    .payload_t(lane_bf16_t)
  ) u_x_buffer (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_data(x_float),
    .wr_vld (x_vld),
    .rd_en  (rd_en),
    .clear  (out_last),
    .rd_data(out_x),
    .rd_vld (out_vld)
  );

  // Gamma slots follow the activation slots, their mask is not replayed
  vector_buffer #(
    .payload_t(lane_bf16_t)
  ) u_gamma_buffer (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_data(in_gamma),
    .wr_vld (in_gamma_vld),
    .rd_en  (rd_en),
    .clear  (out_last),
    .rd_data(out_gamma),
    .rd_vld ()
  );

  replay_control u_replay_control (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_data_num    (in_data_num),
    .in_data_num_vld(in_data_num_vld),
    .sum_sq_vld     (sum_sq_vld),
    .rd_en          (rd_en),
    .out_last       (out_last)
  );

endmodule

`default_nettype wire

/* src/square_accumulator.sv */
`timescale 1ns/10ps
`default_nettype none

module square_accumulator (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [rms_front_pkg::num_width-1:0]       in_k,
  input  logic                                      in_k_vld,
  input  rms_front_pkg::fixed_lanes_t               in_fixed_data,
  input  rms_front_pkg::lane_mask_t                 in_fixed_data_vld,
  input  logic signed [rms_front_pkg::scale_width-1:0] scale_pos,
  input  logic                                      clear,
  output rms_front_pkg::bf16_t                      sum_sq,
  output logic                                      sum_sq_vld
);

  import rms_front_pkg::*;

  logic [num_width-1:0]     k;
  logic                     gate;
  logic [2*fixed_width-1:0] square [lane_count];
  lane_mask_t               square_vld;
  logic [num_width-1:0]     cnt;
  logic [num_width-1:0]     nxt_cnt;
  logic [sum_width-1:0]     sum;
  logic [sum_width-1:0]     nxt_sum;
  logic                     done;
  bf16_t                    sum_flt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      k <= '0;
    end else if (in_k_vld) begin
      k <= in_k;
    end
  end

  // Input gate closes once the K-th element is in and reopens on clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gate <= 1'b0;
    end else if (clear) begin
      gate <= 1'b0;
    end else if (done) begin
      gate <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Stage 1 registers the squares
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!gate || clear) begin
      for (int i = 0; i < lane_count; i++) begin
        square[i] <= signed'(in_fixed_data[i]) * signed'(in_fixed_data[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      square_vld <= '0;
    end else begin
      square_vld <= (gate && !clear) ? '0 : in_fixed_data_vld;
    end
  end

  // --------------------------------------------------------------------------
  // Stage 2 accumulates in lane order up to K
  // --------------------------------------------------------------------------
  always_comb begin
    nxt_cnt = cnt;
    nxt_sum = sum;
    for (int i = 0; i < lane_count; i++) begin
      if (square_vld[i] && nxt_cnt < k) begin
        nxt_cnt = nxt_cnt + 1'b1;
        nxt_sum = nxt_sum + sum_width'(square[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      sum  <= '0;
      done <= 1'b0;
    end else if (clear) begin
      cnt  <= '0;
      sum  <= '0;
      done <= 1'b0;
    end else begin
      cnt  <= nxt_cnt;
      sum  <= nxt_sum;
      // Fires only on the edge where the count reaches K
      done <= (cnt < k) && (nxt_cnt == k);
    end
  end

  // --------------------------------------------------------------------------
  // Stage 3 converts the sum to scaled bfloat16
  // --------------------------------------------------------------------------
  i2flt_bf16 #(
    .in_width(sum_width)
  ) u_i2flt_sum (
    .a(signed'(sum)),
    .z(sum_flt)
  );

  always_ff @(posedge clk) begin
    if (done) begin
      sum_sq <= scale_exponent(sum_flt, scale_pos);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_sq_vld <= 1'b0;
    end else begin
      sum_sq_vld <= done;
    end
  end

  a_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) sum_sq_vld |=> !sum_sq_vld
  );

  a_cnt_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) cnt <= k
  );

endmodule

`default_nettype wire

/* src/vector_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module vector_buffer #(
  parameter type payload_t = rms_front_pkg::lane_bf16_t
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  payload_t                  wr_data,
  input  rms_front_pkg::lane_mask_t wr_vld,
  input  logic                      rd_en,
  input  logic                      clear,
  output payload_t                  rd_data,
  output rms_front_pkg::lane_mask_t rd_vld
);

  import rms_front_pkg::*;

  payload_t   mem      [buffer_depth];
  lane_mask_t mask_mem [buffer_depth];
  slot_ptr_t  wr_ptr;
  slot_ptr_t  rd_ptr;
  slot_ptr_t  wr_idx;
  logic       wr_any;

  assign wr_any = |wr_vld;

  // A write on the clear edge lands in slot 0 of the new vector
  assign wr_idx = clear ? '0 : wr_ptr;

  // --------------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_any) begin
      mem[wr_idx]      <= wr_data;
      mask_mem[wr_idx] <= wr_vld;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= slot_ptr_t'(wr_any);
    end else if (wr_any) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (clear) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // Stored mask of the slot being presented, empty when idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= mask_mem[rd_ptr] & {lane_count{rd_en}};
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_any && !clear) |-> (wr_ptr < slot_ptr_t'(buffer_depth))
  );

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
src/rms_front_pkg.sv
src/i2flt_bf16.sv
src/in_data_convert.sv
src/square_accumulator.sv
src/vector_buffer.sv
src/replay_control.sv
src/rms_front_top.sv
dv/rms_front_tb.sv
